// ==== ising_settings.svh ====
`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// ==================================================
// design sizes
// ==================================================
// number of spins, one J row per spin
`define ISING_NUM_SPIN 8
// precision of J and h
`define ISING_BITJ 4
`define ISING_BITH 4
// unsigned scaling factor applied to h
`define ISING_SCALING_BIT 4
// register stages in the adder tree
`define ISING_PIPES 2

// ==================================================
// derived widths
// ==================================================
// h times scaling factor
`define ISING_MULTBIT (`ISING_BITH + `ISING_SCALING_BIT)
// per-spin energy, 2 guard bits cover the doubling
`define ISING_ENERGY_BIT (`ISING_MULTBIT + $clog2(`ISING_NUM_SPIN) + 2)
// sum over all spins
`define ISING_TOTAL_BIT (`ISING_ENERGY_BIT + $clog2(`ISING_NUM_SPIN))

`endif

// ==== ising_pkg.sv ====
`default_nettype none

`include "ising_settings.svh"

package ising_pkg;

    // sweep controller states
    typedef enum logic [2:0] {
        IDLE,
        FLUSH,
        ISSUE,
        DRAIN,
        DONE
    } sweep_state_e;

    // apb word offsets, J rows follow JROW0 at 4-byte steps
    typedef enum logic [7:0] {
        CTRL   = 8'h00,
        STATUS = 8'h04,
        SPINS  = 8'h08,
        HSCALE = 8'h0C,
        HBIAS  = 8'h10,
        ENERGY = 8'h14,
        JROW0  = 8'h40
    } reg_addr_e;

    // one row of J, entry j sits in bits [4j+3:4j]
    typedef logic [`ISING_NUM_SPIN-1:0][`ISING_BITJ-1:0] weight_row_t;

endpackage

`default_nettype wire

// ==== ising_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ising_settings.svh"

interface ising_cfg_if;

    // driven by the register block
    logic start_pulse;
    logic double_mode;
    logic [`ISING_NUM_SPIN-1:0] spins;
    logic [`ISING_SCALING_BIT-1:0] hscale;
    // eight packed 4-bit biases, bias i in bits [4i+3:4i]
    logic [`ISING_NUM_SPIN*`ISING_BITH-1:0] hbias;
    ising_pkg::weight_row_t [`ISING_NUM_SPIN-1:0] jrows;

    // driven by the sweep controller
    logic busy;
    logic done_pulse;
    logic signed [`ISING_TOTAL_BIT-1:0] total_energy;

    modport regs (
        output start_pulse, double_mode, spins, hscale, hbias, jrows,
        input  busy, done_pulse, total_energy
    );

    modport ctrl (
        input  start_pulse, double_mode, spins, hscale, hbias, jrows,
        output busy, done_pulse, total_energy
    );

endinterface

`default_nettype wire

// ==== bp_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_pipe #(
    parameter int DATAW = 1,
    parameter int PIPES = 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             valid_i,
    input  logic [DATAW-1:0] data_i,
    output logic             valid_o,
    output logic [DATAW-1:0] data_o
);

    if (PIPES == 0) begin : g_wire
        // no stages, pass straight through
        assign valid_o = valid_i;
        assign data_o  = data_i;
    end else begin : g_pipe
        logic [PIPES-1:0] valid_q;
        logic [DATAW-1:0] data_q [PIPES];

        // valid chain, flush drops everything in flight
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                valid_q <= '0;
            end else if (flush_i) begin
                valid_q <= '0;
            end else begin
                valid_q[0] <= valid_i;
                for (int k = 1; k < PIPES; k++) begin
                    valid_q[k] <= valid_q[k-1];
                end
            end
        end

        // data shifts every cycle, qualified by valid
        always_ff @(posedge clk_i) begin
            data_q[0] <= data_i;
            for (int k = 1; k < PIPES; k++) begin
                data_q[k] <= data_q[k-1];
            end
        end

        assign valid_o = valid_q[PIPES-1];
        assign data_o  = data_q[PIPES-1];
    end

endmodule

`default_nettype wire

// ==== adder_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module adder_tree #(
    parameter  int N      = 8,
    parameter  int DATAW  = 8,
    parameter  int PIPES  = 1,
    localparam int LEVELS = $clog2(N),
    localparam int SUMW   = DATAW + LEVELS
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic                              en_i,
    input  logic                              data_valid_i,
    input  logic signed [N-1:0][DATAW-1:0]    data_i,
    output logic signed [SUMW-1:0]            sum_o
);

    // tree width rounded up to a power of two
    localparam int NP = 1 << LEVELS;

    // node[l] holds the words entering level l
    logic signed [SUMW-1:0] node [LEVELS+1][NP];
    logic                   valid [LEVELS+1];

    if (PIPES > LEVELS) begin : g_bad_pipes
        $error("adder_tree needs PIPES no larger than the tree depth");
    end

    // leaves, sign extended to the full sum width
    for (genvar k = 0; k < NP; k++) begin : g_leaf
        if (k < N) begin : g_word
            assign node[0][k] = SUMW'($signed(data_i[k]));
        end else begin : g_pad
            assign node[0][k] = '0;
        end
    end
    assign valid[0] = data_valid_i;

    // ==================================================
    // adder levels
    // ==================================================
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        // spread PIPES registers evenly over the levels
        localparam bit REG = ((l + 1) * PIPES / LEVELS) > (l * PIPES / LEVELS);
        localparam int W   = NP >> (l + 1);

        logic signed [SUMW-1:0] sum_d [W];

        for (genvar k = 0; k < W; k++) begin : g_add
            assign sum_d[k] = node[l][2*k] + node[l][2*k+1];
        end

        if (REG) begin : g_reg
            logic signed [SUMW-1:0] sum_q [W];
            logic                   valid_q;

            // stage holds while disabled, loads only on valid input
            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    valid_q <= 1'b0;
                    sum_q   <= '{default: '0};
                end else if (flush_i) begin
                    valid_q <= 1'b0;
                    sum_q   <= '{default: '0};
                end else if (en_i) begin
                    valid_q <= valid[l];
                    if (valid[l]) begin
                        sum_q <= sum_d;
                    end
                end
            end

            for (genvar k = 0; k < W; k++) begin : g_out
                assign node[l+1][k] = sum_q[k];
            end
            assign valid[l+1] = valid_q;
        end else begin : g_comb
            for (genvar k = 0; k < W; k++) begin : g_out
                assign node[l+1][k] = sum_d[k];
            end
            assign valid[l+1] = valid[l];
        end
    end

    // root, zero when nothing valid comes out
    assign sum_o = valid[LEVELS] ? node[LEVELS][0] : '0;

endmodule

`default_nettype wire

// ==== partial_energy_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ising_settings.svh"

module partial_energy_calc (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                en_i,
    input  logic                                data_valid_i,
    input  logic                                current_spin_i,
    input  logic                                double_weight_contri_i,
    input  logic [`ISING_NUM_SPIN-1:0]          spin_vector_i,
    input  ising_pkg::weight_row_t              weight_i,
    input  logic signed [`ISING_BITH-1:0]       hbias_i,
    input  logic [`ISING_SCALING_BIT-1:0]       hscaling_i,
    output logic signed [`ISING_ENERGY_BIT-1:0] energy_o
);

    localparam int MB = `ISING_MULTBIT;
    localparam int SW = `ISING_MULTBIT + $clog2(`ISING_NUM_SPIN);
    localparam int EW = `ISING_ENERGY_BIT;

    logic signed [`ISING_NUM_SPIN-1:0][MB-1:0] weight_ext;
    logic signed [`ISING_NUM_SPIN-1:0][MB-1:0] mult;
    logic signed [MB-1:0] hbias_ext;
    logic signed [MB-1:0] hbias_scaled;
    logic signed [MB-1:0] hbias_scaled_p;
    logic signed [SW-1:0] wsum;
    logic signed [EW-1:0] wsum_ext;
    logic signed [EW-1:0] wsum_mode;
    logic signed [EW-1:0] energy_local;
    logic                 double_p;
    logic                 spin_p;

    // ==================================================
    // spin products
    // ==================================================
    // J[i][j] for spin j up, -J[i][j] for spin j down
    always_comb begin
        for (int k = 0; k < `ISING_NUM_SPIN; k++) begin
            weight_ext[k] = MB'($signed(weight_i[k]));
            mult[k]       = spin_vector_i[k] ? weight_ext[k] : -weight_ext[k];
        end
    end

    // bias times unsigned scale
    assign hbias_ext    = MB'(hbias_i);
    assign hbias_scaled = hbias_ext * $signed({1'b0, hscaling_i});

    adder_tree #(
        .N     (`ISING_NUM_SPIN),
        .DATAW (MB),
        .PIPES (`ISING_PIPES)
    ) u_adder_tree (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .en_i         (en_i),
        .data_valid_i (data_valid_i),
        .data_i       (mult),
        .sum_o        (wsum)
    );

    // ==================================================
    // side-band delay matched to the tree
    // ==================================================
    bp_pipe #(.DATAW(MB), .PIPES(`ISING_PIPES)) u_pipe_hbias (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (data_valid_i),
        .data_i  (hbias_scaled),
        .valid_o (),
        .data_o  (hbias_scaled_p)
    );

    bp_pipe #(.DATAW(1), .PIPES(`ISING_PIPES)) u_pipe_double (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (data_valid_i),
        .data_i  (double_weight_contri_i),
        .valid_o (),
        .data_o  (double_p)
    );

    bp_pipe #(.DATAW(1), .PIPES(`ISING_PIPES)) u_pipe_spin (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (data_valid_i),
        .data_i  (current_spin_i),
        .valid_o (),
        .data_o  (spin_p)
    );

    // delta form doubles the weight sum
    assign wsum_ext     = EW'(wsum);
    assign wsum_mode    = double_p ? (wsum_ext <<< 1) : wsum_ext;
    // plus twice the scaled bias
    assign energy_local = wsum_mode + (EW'(hbias_scaled_p) <<< 1);
    // sign of the current spin
    assign energy_o     = spin_p ? energy_local : -energy_local;

endmodule

`default_nettype wire

// ==== energy_sweep_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ising_settings.svh"

module energy_sweep_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    ising_cfg_if.ctrl cfg
);

    localparam int IW = $clog2(`ISING_NUM_SPIN);
    localparam int EW = `ISING_ENERGY_BIT;
    localparam int TW = `ISING_TOTAL_BIT;

    ising_pkg::sweep_state_e state_q;
    ising_pkg::sweep_state_e state_d;

    // spin index in ISSUE, drain count in DRAIN
    logic [IW-1:0]        cnt_q;
    logic                 issue;
    logic                 flush;
    logic signed [EW-1:0] energy;
    logic                 energy_valid;
    logic signed [TW-1:0] acc_q;

    // ==================================================
    // sweep FSM
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ising_pkg::IDLE: begin
                if (cfg.start_pulse) begin
                    state_d = ising_pkg::FLUSH;
                end
            end
            ising_pkg::FLUSH: state_d = ising_pkg::ISSUE;
            ising_pkg::ISSUE: begin
                if (cnt_q == IW'(`ISING_NUM_SPIN - 1)) begin
                    state_d = ising_pkg::DRAIN;
                end
            end
            ising_pkg::DRAIN: begin
                // PIPES cycles of latency plus one to accumulate
                if (cnt_q == IW'(`ISING_PIPES)) begin
                    state_d = ising_pkg::DONE;
                end
            end
            default: state_d = ising_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ising_pkg::IDLE;
            cnt_q   <= '0;
            acc_q   <= '0;
        end else begin
            state_q <= state_d;
            // counter restarts on every state change
            if (state_d != state_q) begin
                cnt_q <= '0;
            end else if (issue || state_q == ising_pkg::DRAIN) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // total is cleared at sweep start and held after done
            if (flush) begin
                acc_q <= '0;
            end else if (energy_valid) begin
                acc_q <= acc_q + TW'(energy);
            end
        end
    end

    assign issue = (state_q == ising_pkg::ISSUE);
    assign flush = (state_q == ising_pkg::FLUSH);

    // ==================================================
    // datapath, one spin per cycle
    // ==================================================
    partial_energy_calc u_calc (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .flush_i                (flush),
        .en_i                   (cfg.busy),
        .data_valid_i           (issue),
        .current_spin_i         (cfg.spins[cnt_q]),
        .double_weight_contri_i (cfg.double_mode),
        .spin_vector_i          (cfg.spins),
        .weight_i               (cfg.jrows[cnt_q]),
        .hbias_i                (cfg.hbias[cnt_q*`ISING_BITH +: `ISING_BITH]),
        .hscaling_i             (cfg.hscale),
        .energy_o               (energy)
    );

    // valid flag delayed like the calculator result
    bp_pipe #(.DATAW(1), .PIPES(`ISING_PIPES)) u_pipe_valid (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush),
        .valid_i (issue),
        .data_i  (1'b0),
        .valid_o (energy_valid),
        .data_o  ()
    );

    assign cfg.busy         = flush || issue || (state_q == ising_pkg::DRAIN);
    assign cfg.done_pulse   = (state_q == ising_pkg::DONE);
    assign cfg.total_energy = acc_q;

endmodule

`default_nettype wire

// ==== ising_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ising_settings.svh"

module ising_apb_regs (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        done_o,
    ising_cfg_if.regs   cfg
);

    localparam int IW = $clog2(`ISING_NUM_SPIN);
    localparam logic [7:0] JBASE = ising_pkg::JROW0;

    logic          wr_en;
    logic          rd_first;
    logic          rd_done;
    logic          jrow_hit;
    logic [IW-1:0] jrow_idx;
    logic          protect_hit;
    logic          wr_err;
    logic          rd_wait_q;
    logic          done_q;
    logic [31:0]   rdata_d;

    // ==================================================
    // apb decode
    // ==================================================
    assign wr_en    = psel_i & penable_i & pwrite_i;
    // reads take one wait state
    assign rd_first = psel_i & penable_i & ~pwrite_i & ~rd_wait_q;
    assign rd_done  = psel_i & penable_i & ~pwrite_i & rd_wait_q;

    // J rows occupy 0x40..0x5C
    assign jrow_hit = (paddr_i[7:IW+2] == JBASE[7:IW+2]) && (paddr_i[1:0] == 2'b00);
    assign jrow_idx = paddr_i[IW+1:2];

    // sweep inputs are locked while busy
    assign protect_hit = jrow_hit || (paddr_i == ising_pkg::SPINS) ||
                         (paddr_i == ising_pkg::HSCALE) || (paddr_i == ising_pkg::HBIAS);
    assign wr_err      = wr_en & protect_hit & cfg.busy;

    assign pready_o  = psel_i & penable_i & (pwrite_i | rd_wait_q);
    assign pslverr_o = wr_err;
    assign done_o    = done_q;

    // ==================================================
    // control state
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_wait_q       <= 1'b0;
            done_q          <= 1'b0;
            cfg.start_pulse <= 1'b0;
            cfg.double_mode <= 1'b0;
        end else begin
            rd_wait_q       <= rd_first;
            cfg.start_pulse <= 1'b0;
            // CTRL writes are ignored during a sweep
            if (wr_en && !cfg.busy && paddr_i == ising_pkg::CTRL) begin
                cfg.start_pulse <= pwdata_i[0];
                cfg.double_mode <= pwdata_i[1];
            end
            // sticky done, set wins over read clear
            if (cfg.done_pulse) begin
                done_q <= 1'b1;
            end else if (rd_done && paddr_i == ising_pkg::STATUS) begin
                done_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // sweep data and read data
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (wr_en && !wr_err) begin
            if (jrow_hit) begin
                cfg.jrows[jrow_idx] <= pwdata_i;
            end
            case (paddr_i)
                ising_pkg::SPINS:  cfg.spins  <= pwdata_i[`ISING_NUM_SPIN-1:0];
                ising_pkg::HSCALE: cfg.hscale <= pwdata_i[`ISING_SCALING_BIT-1:0];
                ising_pkg::HBIAS:  cfg.hbias  <= pwdata_i;
                default: ;
            endcase
        end
        // capture in the first access cycle, hold through the wait state
        if (rd_first) begin
            prdata_o <= rdata_d;
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        rdata_d = '0;
        if (jrow_hit) begin
            rdata_d = cfg.jrows[jrow_idx];
        end else begin
            case (paddr_i)
                ising_pkg::CTRL:   rdata_d = {30'b0, cfg.double_mode, 1'b0};
                ising_pkg::STATUS: rdata_d = {30'b0, done_q, cfg.busy};
                ising_pkg::SPINS:  rdata_d = 32'(cfg.spins);
                ising_pkg::HSCALE: rdata_d = 32'(cfg.hscale);
                ising_pkg::HBIAS:  rdata_d = cfg.hbias;
                // total is sign extended to the bus width
                ising_pkg::ENERGY: rdata_d = 32'(cfg.total_energy);
                default:           rdata_d = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ising_energy_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ising_energy_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // apb slave
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    // sticky sweep done, cleared by a STATUS read
    output logic        done_o
);

    // configuration and sweep handshake
    ising_cfg_if cfg_if ();

    ising_apb_regs u_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .done_o    (done_o),
        .cfg       (cfg_if.regs)
    );

    energy_sweep_ctrl u_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cfg     (cfg_if.ctrl)
    );

endmodule

`default_nettype wire

// ==== ising_energy_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ising_settings.svh"

module ising_energy_sva (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  logic pready_i,
    input  logic pslverr_i,
    input  logic done_i,
    input  logic busy_i,
    input  logic start_i,
    input  logic done_pulse_i
);

    // flush, one issue per spin, drain, then the done cycle
    localparam int DONE_LAT = `ISING_NUM_SPIN + `ISING_PIPES + 3;

    // read by the testbench at the end of the run
    int unsigned err_cnt = 0;

    // error response only on a completing cycle
    a_slverr_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> pready_i)
    else begin
        err_cnt++;
        $error("pslverr high without pready");
    end

    // sticky done only rises once the sweep has ended
    a_done_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(done_i) |-> !busy_i)
    else begin
        err_cnt++;
        $error("done_o rose during a sweep");
    end

    // one wait state on reads, then completion
    a_read_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i && !pwrite_i && !pready_i) |=> pready_i)
    else begin
        err_cnt++;
        $error("apb read took more than two access cycles");
    end

    // fixed sweep length from the accepted start
    a_done_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> ##DONE_LAT done_pulse_i)
    else begin
        err_cnt++;
        $error("done strobe not at the expected cycle after start");
    end

endmodule

bind ising_energy_top ising_energy_sva u_sva (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pready_i     (pready_o),
    .pslverr_i    (pslverr_o),
    .done_i       (done_o),
    .busy_i       (cfg_if.busy),
    .start_i      (cfg_if.start_pulse),
    .done_pulse_i (cfg_if.done_pulse)
);

`default_nettype wire

// ==== ising_energy_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ising_settings.svh"

module ising_energy_tb;

    localparam int NS = `ISING_NUM_SPIN;
    localparam int BJ = `ISING_BITJ;
    localparam int BH = `ISING_BITH;
    localparam int SWEEP_CYCLES = `ISING_NUM_SPIN + `ISING_PIPES + 3;
    // reset, 6 sweeps and about 60 apb accesses of up to 4 cycles, margin of 2
    localparam int TIMEOUT_CYCLES = 2 * (16 + 6 * SWEEP_CYCLES + 60 * 4);

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        done_o;

    // register images for the reference model
    logic [NS*BJ-1:0] jrow_m [NS];
    logic [NS-1:0]    spins_m;
    logic [`ISING_SCALING_BIT-1:0] hscale_m;
    logic [NS*BH-1:0] hbias_m;

    int seed = 23;
    int cycle_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int fail_mark = 0;
    logic [31:0] e_a;
    logic [31:0] e_b;
    logic [31:0] rd;
    logic        err;

    always #20 clk = ~clk;

    ising_energy_top UUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .done_o    (done_o)
    );

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    // ==================================================
    // checks and apb access
    // ==================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) pass_cnt = pass_cnt + 1;
        else begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            fail_cnt = fail_cnt + 1;
        end
    endtask

    // setup cycle, access cycle, wait while pready low, sample at negedge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < 4) begin
            waits++;
            @(negedge clk);
        end
        assert (pready === 1'b1) pass_cnt = pass_cnt + 1;
        else begin
            $display("apb access to 0x%02h never completed", addr);
            fail_cnt = fail_cnt + 1;
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        slverr;
        apb_access(1'b1, addr, data, unused, slverr);
        check_value("pslverr", 32'(slverr), 32'h0);
    endtask

    task automatic expect_read(input string name, input logic [7:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic        slverr;
        apb_access(1'b0, addr, 32'h0, data, slverr);
        check_value(name, data, exp);
        // reads never raise an error response
        check_value("pslverr", 32'(slverr), 32'h0);
    endtask

    function automatic logic [7:0] jrow_addr(input int i);
        return 8'(ising_pkg::JROW0) + 8'(4 * i);
    endfunction

    // ==================================================
    // reference model
    // ==================================================
    function automatic int model_energy(input logic dbl);
        int total;
        int local_sum;
        int jv;
        int hv;
        int e;
        total = 0;
        for (int i = 0; i < NS; i++) begin
            local_sum = 0;
            // +J for an up spin j, -J for a down one
            for (int j = 0; j < NS; j++) begin
                jv = int'($signed(jrow_m[i][j*BJ +: BJ]));
                local_sum += spins_m[j] ? jv : -jv;
            end
            if (dbl) begin
                local_sum = 2 * local_sum;
            end
            hv = int'($signed(hbias_m[i*BH +: BH]));
            e  = local_sum + 2 * hv * int'(hscale_m);
            // sign of spin i
            total += spins_m[i] ? e : -e;
        end
        return total;
    endfunction

    task automatic write_config();
        for (int i = 0; i < NS; i++) begin
            reg_write(jrow_addr(i), jrow_m[i]);
        end
        reg_write(ising_pkg::SPINS, 32'(spins_m));
        reg_write(ising_pkg::HSCALE, 32'(hscale_m));
        reg_write(ising_pkg::HBIAS, 32'(hbias_m));
    endtask

    task automatic start_sweep(input logic dbl);
        reg_write(ising_pkg::CTRL, {30'b0, dbl, 1'b1});
    endtask

    // wait for sticky done, check total, then clear done via STATUS
    task automatic finish_sweep(input logic dbl, output logic [31:0] energy);
        int n;
        logic slverr;
        n = 0;
        @(negedge clk);
        while (!done_o && n < 3 * SWEEP_CYCLES) begin
            n++;
            @(negedge clk);
        end
        assert (done_o === 1'b1) pass_cnt = pass_cnt + 1;
        else begin
            $display("sweep gave no done_o within %0d cycles", 3 * SWEEP_CYCLES);
            fail_cnt = fail_cnt + 1;
        end
        apb_access(1'b0, ising_pkg::ENERGY, 32'h0, energy, slverr);
        check_value("ENERGY", energy, 32'(model_energy(dbl)));
        check_value("pslverr", 32'(slverr), 32'h0);
        expect_read("STATUS", ising_pkg::STATUS, 32'h2);
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, fail_cnt - fail_mark);
        fail_mark = fail_cnt;
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        rst_n   <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= 8'h0;
        pwdata  <= 32'h0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // reset values and plain register readback
        expect_read("STATUS", ising_pkg::STATUS, 32'h0);
        expect_read("ENERGY", ising_pkg::ENERGY, 32'h0);
        @(negedge clk);
        check_value("done_o", 32'(done_o), 32'h0);
        for (int i = 0; i < NS; i++) begin
            jrow_m[i] = $random(seed);
        end
        spins_m  = NS'($random(seed));
        hscale_m = `ISING_SCALING_BIT'($random(seed));
        hbias_m  = $random(seed);
        write_config();
        for (int i = 0; i < NS; i++) begin
            expect_read($sformatf("JROW%0d", i), jrow_addr(i), jrow_m[i]);
        end
        expect_read("SPINS", ising_pkg::SPINS, 32'(spins_m));
        expect_read("HSCALE", ising_pkg::HSCALE, 32'(hscale_m));
        expect_read("HBIAS", ising_pkg::HBIAS, 32'(hbias_m));
        end_test(1, "reset state and readback");

        start_sweep(1'b0);
        finish_sweep(1'b0, e_a);
        end_test(2, "plain mode energy");

        // delta form, then a global spin flip without bias
        start_sweep(1'b1);
        finish_sweep(1'b1, e_a);
        hbias_m = '0;
        spins_m = '1;
        reg_write(ising_pkg::HBIAS, 32'(hbias_m));
        reg_write(ising_pkg::SPINS, 32'(spins_m));
        start_sweep(1'b1);
        finish_sweep(1'b1, e_a);
        spins_m = '0;
        reg_write(ising_pkg::SPINS, 32'(spins_m));
        start_sweep(1'b1);
        finish_sweep(1'b1, e_b);
        check_value("ENERGY flip symmetry", e_b, e_a);
        end_test(3, "double mode energy");

        // J row locked during a sweep
        spins_m = NS'($random(seed));
        hbias_m = $random(seed);
        reg_write(ising_pkg::SPINS, 32'(spins_m));
        reg_write(ising_pkg::HBIAS, 32'(hbias_m));
        start_sweep(1'b0);
        apb_access(1'b1, jrow_addr(3), ~jrow_m[3], rd, err);
        check_value("pslverr", 32'(err), 32'h1);
        finish_sweep(1'b0, e_a);
        expect_read("JROW3", jrow_addr(3), jrow_m[3]);
        end_test(4, "write protection while busy");

        // second start with double mode is dropped
        start_sweep(1'b0);
        reg_write(ising_pkg::CTRL, 32'h3);
        finish_sweep(1'b0, e_a);
        expect_read("CTRL", ising_pkg::CTRL, 32'h0);
        expect_read("STATUS", ising_pkg::STATUS, 32'h0);
        @(negedge clk);
        check_value("done_o", 32'(done_o), 32'h0);
        end_test(5, "start ignored while busy");

        $display("checks: %0d passed, %0d failed, %0d assertion errors",
                 pass_cnt, fail_cnt, UUT.u_sva.err_cnt);
        if (fail_cnt == 0 && UUT.u_sva.err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
ising_pkg.sv
ising_cfg_if.sv
bp_pipe.sv
adder_tree.sv
partial_energy_calc.sv
energy_sweep_ctrl.sv
ising_apb_regs.sv
ising_energy_top.sv
ising_energy_sva.sv
ising_energy_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ising energy testbench, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f src.f --top-module ising_energy_tb -o sim_ising \
    || { echo "verilator build error"; exit 1; }
./obj_dir/sim_ising 2>&1 | tee sim.log
grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
